/* verilog/blimp_consts.svh */
// --------------------
// Blimp core constants
// Reset pc, RV32 opcode and funct values, nop encoding
// --------------------

`ifndef BLIMP_CONSTS_SVH
`define BLIMP_CONSTS_SVH

// First fetch address out of reset
`define BLIMP_RESET_PC  32'h0000_0000

// Major opcodes
`define BLIMP_OPC_OP    7'b0110011
`define BLIMP_OPC_OPIMM 7'b0010011

// funct3 shared by add, addi and mul
`define BLIMP_F3_ADD    3'b000

// funct7 selects add vs mul within OP
`define BLIMP_F7_ADD    7'b0000000
`define BLIMP_F7_MUL    7'b0000001

// addi x0, x0, 0
`define BLIMP_NOP       32'h0000_0013

`endif

/* verilog/blimp_pkg.sv */
// --------------------
// Blimp shared types
// Wishbone bundles, pipeline messages, trace record, operation enum
// --------------------

package blimp_pkg;

  // Wishbone classic instruction port, read only
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_imem_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_imem_rsp_t;

  // Decoded operation
  typedef enum logic [1:0] {
    OP_ADD,
    OP_ADDI,
    OP_MUL,
    OP_NOP
  } blimp_op_t;

  // Fetch FSM states
  typedef enum logic {
    FETCH_IDLE,
    FETCH_BUSY
  } fetch_state_t;

  // Fetch to decode
  typedef struct packed {
    logic        val;
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_msg_t;

  // Decode to execute, operands already resolved
  typedef struct packed {
    logic        val;
    logic [31:0] pc;
    blimp_op_t   op;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] opa;
    logic [31:0] opb;
  } decode_msg_t;

  // One retired instruction
  typedef struct packed {
    logic        val;
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } inst_trace_t;

  // Writeback, doubles as decode bypass
  typedef struct packed {
    logic        wen;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } rf_write_t;

endpackage

/* verilog/blimp_fetch.sv */
// --------------------
// Blimp fetch stage
// Wishbone classic read master, owns the pc
// --------------------

`timescale 1ns/1ps

`include "blimp_consts.svh"

module blimp_fetch (
  input  logic                    clk,
  input  logic                    rst,
  output blimp_pkg::wb_imem_req_t wb_req,
  input  blimp_pkg::wb_imem_rsp_t wb_rsp,
  output blimp_pkg::fetch_msg_t   fetch_out
);

  blimp_pkg::fetch_state_t state;
  logic [31:0]             pc;
  logic                    accept;

  // --------------------
  // Request FSM
  // --------------------

  // Idle only while in reset, then requests forever
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= blimp_pkg::FETCH_IDLE;
    end else begin
      unique case (state)
        blimp_pkg::FETCH_IDLE: state <= blimp_pkg::FETCH_BUSY;
        blimp_pkg::FETCH_BUSY: state <= blimp_pkg::FETCH_BUSY;
        default:               state <= blimp_pkg::FETCH_IDLE;
      endcase
    end
  end

  // Ack only counts while our cycle is open
  assign accept = (state == blimp_pkg::FETCH_BUSY) && wb_rsp.ack;

  // Bus request straight from state, adr held at pc until ack
  always_comb begin
    wb_req.cyc = (state == blimp_pkg::FETCH_BUSY);
    wb_req.stb = (state == blimp_pkg::FETCH_BUSY);
    wb_req.adr = pc;
  end

  // --------------------
  // Program counter
  // --------------------

  // Next address goes out the cycle after ack, stb stays up
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `BLIMP_RESET_PC;
    end else if (accept) begin
      pc <= pc + 32'd4;
    end
  end

  // --------------------
  // Fetched instruction
  // --------------------

  // Valid for exactly one cycle per ack
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_out.val <= 1'b0;
    end else begin
      fetch_out.val <= accept;
    end
  end

  // Payload captured on ack
  always_ff @(posedge clk) begin
    if (accept) begin
      fetch_out.pc   <= pc;
      fetch_out.inst <= wb_rsp.dat;
    end
  end

endmodule

/* verilog/blimp_decode.sv */
// --------------------
// Blimp decode stage
// Classifies the op, reads operands with bypass, registers the result
// --------------------

`timescale 1ns/1ps

`include "blimp_consts.svh"

module blimp_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  blimp_pkg::fetch_msg_t  fetch_in,
  output logic [4:0]             raddr0,
  output logic [4:0]             raddr1,
  input  logic [31:0]            rdata0,
  input  logic [31:0]            rdata1,
  input  blimp_pkg::rf_write_t   bypass,
  output blimp_pkg::decode_msg_t decode_out
);

  logic [6:0]          opcode;
  logic [4:0]          rd;
  logic [2:0]          funct3;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [6:0]          funct7;
  logic [31:0]         imm_i;
  blimp_pkg::blimp_op_t op;
  logic [31:0]         src0;
  logic [31:0]         src1;

  // --------------------
  // Field split
  // --------------------

  assign opcode = fetch_in.inst[6:0];
  assign rd     = fetch_in.inst[11:7];
  assign funct3 = fetch_in.inst[14:12];
  assign rs1    = fetch_in.inst[19:15];
  assign rs2    = fetch_in.inst[24:20];
  assign funct7 = fetch_in.inst[31:25];

  // I-type immediate, sign extended
  assign imm_i = {{20{fetch_in.inst[31]}}, fetch_in.inst[31:20]};

  // Operation select, anything unknown falls to nop
  always_comb begin
    op = blimp_pkg::OP_NOP;
    if (opcode == `BLIMP_OPC_OPIMM && funct3 == `BLIMP_F3_ADD) begin
      op = blimp_pkg::OP_ADDI;
    end else if (opcode == `BLIMP_OPC_OP && funct3 == `BLIMP_F3_ADD) begin
      if (funct7 == `BLIMP_F7_ADD) begin
        op = blimp_pkg::OP_ADD;
      end else if (funct7 == `BLIMP_F7_MUL) begin
        op = blimp_pkg::OP_MUL;
      end
    end
  end

  // --------------------
  // Operand read
  // --------------------

  assign raddr0 = rs1;
  assign raddr1 = rs2;

  // Execute result not yet in the array, take it from the bypass
  always_comb begin
    src0 = rdata0;
    src1 = rdata1;
    if (bypass.wen && bypass.waddr != 5'd0 && bypass.waddr == rs1) begin
      src0 = bypass.wdata;
    end
    if (bypass.wen && bypass.waddr != 5'd0 && bypass.waddr == rs2) begin
      src1 = bypass.wdata;
    end
  end

  // --------------------
  // Pipeline register
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_out.val <= 1'b0;
    end else begin
      decode_out.val <= fetch_in.val;
    end
  end

  // rd of x0 never writes
  always_ff @(posedge clk) begin
    decode_out.pc    <= fetch_in.pc;
    decode_out.op    <= op;
    decode_out.waddr <= rd;
    decode_out.wen   <= (op != blimp_pkg::OP_NOP) && (rd != 5'd0);
    decode_out.opa   <= src0;
    decode_out.opb   <= (op == blimp_pkg::OP_ADDI) ? imm_i : src1;
  end

endmodule

/* verilog/blimp_regfile.sv */
// --------------------
// Blimp register file
// 32 x 32, two async reads, one sync write, x0 reads zero
// --------------------

`timescale 1ns/1ps

module blimp_regfile (
  input  logic                 clk,
  input  logic [4:0]           raddr0,
  input  logic [4:0]           raddr1,
  output logic [31:0]          rdata0,
  output logic [31:0]          rdata1,
  input  blimp_pkg::rf_write_t wr
);

  logic [31:0] regs [0:31];

  // Read ports
  // x0 forced to zero, array entry 0 is never written
  always_comb begin
    rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
    rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  end

  // Write port
  always_ff @(posedge clk) begin
    if (wr.wen && wr.waddr != 5'd0) begin
      regs[wr.waddr] <= wr.wdata;
    end
  end

endmodule

/* verilog/blimp_execute.sv */
// --------------------
// Blimp execute stage
// Single-cycle add/mul, writeback bundle and trace from one register
// --------------------

`timescale 1ns/1ps

module blimp_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  blimp_pkg::decode_msg_t decode_in,
  output blimp_pkg::rf_write_t   rf_wr,
  output blimp_pkg::inst_trace_t trace
);

  logic [31:0] sum;
  logic [31:0] product;
  logic [31:0] result;
  logic        do_write;

  // --------------------
  // ALU
  // --------------------

  assign sum     = decode_in.opa + decode_in.opb;
  // Low half of the product only
  assign product = decode_in.opa * decode_in.opb;

  always_comb begin
    unique case (decode_in.op)
      blimp_pkg::OP_ADD,
      blimp_pkg::OP_ADDI: result = sum;
      blimp_pkg::OP_MUL:  result = product;
      default:            result = 32'd0;
    endcase
  end

  assign do_write = decode_in.val && decode_in.wen;

  // --------------------
  // Trace register
  // --------------------

  // Control bits
  always_ff @(posedge clk) begin
    if (rst) begin
      trace.val <= 1'b0;
      trace.wen <= 1'b0;
    end else begin
      trace.val <= decode_in.val;
      trace.wen <= do_write;
    end
  end

  // Payload, wdata zero when nothing is written
  always_ff @(posedge clk) begin
    trace.pc    <= decode_in.pc;
    trace.waddr <= decode_in.waddr;
    trace.wdata <= do_write ? result : 32'd0;
  end

  // --------------------
  // Writeback
  // --------------------

  // Same register as the trace, so write and retire line up
  always_comb begin
    rf_wr.wen   = trace.wen;
    rf_wr.waddr = trace.waddr;
    rf_wr.wdata = trace.wdata;
  end

endmodule

/* verilog/blimp_core.sv */
// --------------------
// Blimp core top
// Fetch, decode, register file and execute
// --------------------

`timescale 1ns/1ps

module blimp_core (
  input  logic                    clk,
  input  logic                    rst,
  output blimp_pkg::wb_imem_req_t wb_req,
  input  blimp_pkg::wb_imem_rsp_t wb_rsp,
  output blimp_pkg::inst_trace_t  trace
);

  blimp_pkg::fetch_msg_t  fetch_msg;
  blimp_pkg::decode_msg_t decode_msg;
  blimp_pkg::rf_write_t   rf_wr;
  logic [4:0]             raddr0;
  logic [4:0]             raddr1;
  logic [31:0]            rdata0;
  logic [31:0]            rdata1;

  // Instruction fetch over Wishbone
  blimp_fetch i_fetch (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .fetch_out (fetch_msg)
  );

  // Decode reads the array and takes the execute bypass
  blimp_decode i_decode (
    .clk        (clk),
    .rst        (rst),
    .fetch_in   (fetch_msg),
    .raddr0     (raddr0),
    .raddr1     (raddr1),
    .rdata0     (rdata0),
    .rdata1     (rdata1),
    .bypass     (rf_wr),
    .decode_out (decode_msg)
  );

  blimp_regfile i_regfile (
    .clk    (clk),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wr     (rf_wr)
  );

  // Retire point
  blimp_execute i_execute (
    .clk       (clk),
    .rst       (rst),
    .decode_in (decode_msg),
    .rf_wr     (rf_wr),
    .trace     (trace)
  );

endmodule

/* tests/blimp_tb_mem.sv */
// --------------------
// Blimp instruction memory model
// Wishbone classic read slave with random wait states
// --------------------

`timescale 1ns/1ps

`include "blimp_consts.svh"

module blimp_tb_mem (
  input  logic                    clk,
  input  logic                    rst,
  input  blimp_pkg::wb_imem_req_t req,
  output blimp_pkg::wb_imem_rsp_t rsp
);

  logic [31:0] words [0:255];
  logic [31:0] lfsr;
  logic        started;
  logic        no_wait;
  logic [1:0]  wait_left;
  logic [1:0]  wait_now;

  initial begin
    lfsr      = 32'h2ce4;
    rsp       = '0;
    started   = 1'b0;
    no_wait   = 1'b0;
    wait_left = 2'd0;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Wait of 0 to 3 cycles from two LFSR bits
  function automatic logic [1:0] draw_wait();
    logic [1:0] v;
    int         i;
    v = 2'd0;
    for (i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[0], lfsr[0]};
    end
    return v;
  endfunction

  // Unloaded words are nops whose immediate folds in the address
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    logic [11:0] imm;
    imm = adr[11:0] ^ adr[23:12] ^ {4'd0, adr[31:24]};
    return `BLIMP_NOP | {imm, 20'd0};
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] adr);
    if (adr[31:10] == 22'd0) begin
      return words[adr[9:2]];
    end
    return fill_word(adr);
  endfunction

  // --------------------
  // Loading
  // --------------------

  task automatic fill_all();
    int i;
    for (i = 0; i < 256; i++) begin
      words[i] = fill_word(i * 4);
    end
  endtask

  task automatic load_word(input int idx, input logic [31:0] word);
    words[idx[7:0]] = word;
  endtask

  // Acks without wait states while set
  task automatic set_no_wait(input logic on);
    no_wait = on;
  endtask

  // --------------------
  // Bus response
  // --------------------

  // Ack lasts one cycle with dat valid alongside
  always @(posedge clk) begin
    if (rst) begin
      rsp.ack <= 1'b0;
      started <= 1'b0;
    end else if (rsp.ack) begin
      rsp.ack <= 1'b0;
      started <= 1'b0;
    end else if (req.cyc && req.stb) begin
      // New cycle draws its wait and an open one counts down
      if (no_wait) begin
        wait_now = 2'd0;
      end else begin
        wait_now = started ? wait_left : draw_wait();
      end
      started <= 1'b1;
      if (wait_now == 2'd0) begin
        rsp.ack <= 1'b1;
        rsp.dat <= word_at(req.adr);
      end else begin
        wait_left <= wait_now - 2'd1;
      end
    end
  end

endmodule

/* tests/blimp_tb.sv */
// --------------------
// Blimp core testbench
// Directed and random programs checked against a golden model
// --------------------

`timescale 1ns/1ps

`include "blimp_consts.svh"

module blimp_tb;

  logic                    clk = 1'b0;
  logic                    rst = 1'b1;
  blimp_pkg::wb_imem_req_t wb_req;
  blimp_pkg::wb_imem_rsp_t wb_rsp;
  blimp_pkg::inst_trace_t  trace;

  // Golden model and expected retire order
  logic [31:0]             model_regs [0:31];
  logic [31:0]             prog_q [$];
  blimp_pkg::inst_trace_t  exp_q [$];
  blimp_pkg::inst_trace_t  want;
  logic [31:0]             lfsr = 32'h2ce4;
  logic [31:0]             last_pc;
  logic                    have_last = 1'b0;
  int                      cycles = 0;
  int                      cycle_limit = 0;

  always #20 clk = ~clk;

  blimp_core i_dut (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .trace  (trace)
  );

  blimp_tb_mem i_mem (
    .clk (clk),
    .rst (rst),
    .req (wb_req),
    .rsp (wb_rsp)
  );

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = 32'd0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input int imm);
    return {imm[11:0], rs1, `BLIMP_F3_ADD, rd, `BLIMP_OPC_OPIMM};
  endfunction

  function automatic logic [31:0] enc_rtype(input logic [6:0] f7, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, `BLIMP_F3_ADD, rd, `BLIMP_OPC_OP};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Queue a program word with its expected record and update the model
  task automatic expect_retire(input logic [31:0] word, input logic [4:0] rd,
                               input logic [31:0] value, input logic writes);
    blimp_pkg::inst_trace_t rec;
    rec.val   = 1'b1;
    rec.pc    = `BLIMP_RESET_PC + 32'(4 * prog_q.size());
    rec.waddr = rd;
    rec.wen   = writes && (rd != 5'd0);
    rec.wdata = rec.wen ? value : 32'd0;
    if (rec.wen) begin
      model_regs[rd] = value;
    end
    prog_q.push_back(word);
    exp_q.push_back(rec);
    cycle_limit += 10;
  endtask

  task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    expect_retire(enc_addi(rd, rs1, imm), rd, model_regs[rs1] + imm, 1'b1);
  endtask

  task automatic do_add(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    expect_retire(enc_rtype(`BLIMP_F7_ADD, rd, rs1, rs2), rd,
                  model_regs[rs1] + model_regs[rs2], 1'b1);
  endtask

  // Only the low word of the full product is written
  task automatic do_mul(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [63:0] full;
    full = {32'd0, model_regs[rs1]} * {32'd0, model_regs[rs2]};
    expect_retire(enc_rtype(`BLIMP_F7_MUL, rd, rs1, rs2), rd, full[31:0], 1'b1);
  endtask

  // --------------------
  // Run control
  // --------------------

  // Holds the core in reset and empties the program
  task automatic begin_test();
    cycle_limit += 16;
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    prog_q.delete();
    exp_q.delete();
    have_last = 1'b0;
  endtask

  // Loads the program and releases reset after 16 cycles in total
  task automatic start_program();
    int i;
    i_mem.fill_all();
    for (i = 0; i < prog_q.size(); i++) begin
      i_mem.load_word(i, prog_q[i]);
    end
    repeat (15) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  // Trace monitor on the falling edge
  always @(negedge clk) begin
    if (!rst && trace.val) begin
      if (have_last) begin
        check_value(trace.pc, last_pc + 32'd4, "pc step");
      end else begin
        check_value(trace.pc, `BLIMP_RESET_PC, "first pc after reset");
      end
      if (!trace.wen) begin
        check_value(trace.wdata, 32'd0, "wdata with wen low");
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        check_value(trace.pc, want.pc, "pc");
        check_value({27'd0, trace.waddr}, {27'd0, want.waddr}, "waddr");
        check_value(trace.wdata, want.wdata, "wdata");
        check_value({31'd0, trace.wen}, {31'd0, want.wen}, "wen");
      end else begin
        // Fill words past the program are nops
        check_value({31'd0, trace.wen}, 32'd0, "wen past the program");
      end
      last_pc   = trace.pc;
      have_last = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the core did not retire its program within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // Tests
  // --------------------

  task automatic test_addi_chain();
    begin_test();
    do_addi(5'd1, 5'd0, 5);
    do_addi(5'd2, 5'd0, -3);
    do_addi(5'd3, 5'd1, 100);
    do_addi(5'd4, 5'd2, -2048);
    do_addi(5'd5, 5'd3, 2047);
    do_addi(5'd1, 5'd1, -1);
    start_program();
    drain();
  endtask

  // Each add reads the result just before it
  task automatic test_add_bypass();
    begin_test();
    do_addi(5'd6, 5'd0, 7);
    do_add(5'd7, 5'd6, 5'd6);
    do_add(5'd8, 5'd7, 5'd6);
    do_add(5'd9, 5'd8, 5'd7);
    do_add(5'd10, 5'd9, 5'd9);
    do_add(5'd10, 5'd10, 5'd8);
    // Zero wait keeps each producer in execute while its consumer decodes
    i_mem.set_no_wait(1'b1);
    start_program();
    drain();
    i_mem.set_no_wait(1'b0);
  endtask

  task automatic test_mul_overflow();
    begin_test();
    do_addi(5'd11, 5'd0, -1);
    do_addi(5'd12, 5'd0, 2047);
    do_mul(5'd13, 5'd11, 5'd11);
    do_mul(5'd14, 5'd12, 5'd12);
    do_mul(5'd15, 5'd14, 5'd14);
    do_mul(5'd16, 5'd15, 5'd11);
    do_mul(5'd17, 5'd11, 5'd12);
    start_program();
    drain();
  endtask

  // x0 targets and unknown encodings retire without a write
  task automatic test_x0_and_unknown();
    begin_test();
    do_addi(5'd18, 5'd0, 9);
    do_addi(5'd0, 5'd0, 123);
    do_add(5'd0, 5'd18, 5'd18);
    do_mul(5'd0, 5'd18, 5'd18);
    expect_retire(enc_rtype(7'b0100000, 5'd19, 5'd18, 5'd18), 5'd19, 32'd0, 1'b0);
    expect_retire(32'hffff_ffff, 5'd31, 32'd0, 1'b0);
    do_add(5'd20, 5'd0, 5'd18);
    start_program();
    drain();
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    int          k;
    begin_test();
    for (k = 1; k < 8; k++) begin
      do_addi(k[4:0], 5'd0, k * 37 - 100);
    end
    for (k = 0; k < 40; k++) begin
      r = rand_bits(20);
      case (r[1:0])
        2'd1:    do_add({2'b00, r[4:2]}, {2'b00, r[7:5]}, {2'b00, r[10:8]});
        2'd2:    do_mul({2'b00, r[4:2]}, {2'b00, r[7:5]}, {2'b00, r[10:8]});
        default: do_addi({2'b00, r[4:2]}, {2'b00, r[7:5]}, {{20{r[19]}}, r[19:8]});
      endcase
    end
    start_program();
    drain();
  endtask

  // Reset lands mid-program and the rerun starts again at the reset pc
  task automatic test_reset_order();
    int k;
    begin_test();
    for (k = 0; k < 8; k++) begin
      do_addi(k[4:0] + 5'd22, 5'd0, k - 4);
    end
    start_program();
    while (exp_q.size() > 5) begin
      @(posedge clk);
    end
    begin_test();
    for (k = 0; k < 8; k++) begin
      do_addi(k[4:0] + 5'd22, 5'd0, k - 4);
    end
    start_program();
    drain();
  endtask

  initial begin
    int i;
    for (i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    test_addi_chain();
    test_add_bypass();
    test_mul_overflow();
    test_x0_and_unknown();
    test_random_mix();
    test_reset_order();
    $display("TB PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/blimp_pkg.sv
verilog/blimp_fetch.sv
verilog/blimp_decode.sv
verilog/blimp_regfile.sv
verilog/blimp_execute.sv
verilog/blimp_core.sv
tests/blimp_tb_mem.sv
tests/blimp_tb.sv

/* Makefile */
# Verilator build and run of the Blimp core testbench

sim:
	verilator --binary -Wno-fatal --top-module blimp_tb -f flist.f -o blimp_sim
	./obj_dir/blimp_sim | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
